//--- verilog/cdr_pkg.sv
package cdr_pkg;

    // array sizes
    localparam int Nadc = 8;        // adc sample width
    localparam int Nti  = 16;       // interleaved lanes per word
    localparam int Npi  = 8;        // pi control word width
    localparam int Nout = 4;        // number of pi control lanes
    localparam int Nerr = Nadc + 2; // phase error width

    // loop configuration, gains are left-shift amounts
    typedef struct packed {
        logic [2:0]             kp;
        logic [2:0]             ki;
        logic [2:0]             kr;
        logic signed [Nerr-1:0] pd_offset;      // removed from the detector output
        logic                   en_freq_est;
        logic                   en_ramp_est;
        logic                   en_ext_pi_ctl;  // all pi lanes take ext_pi_ctl
        logic [Npi-1:0]         ext_pi_ctl;
    } cdr_cfg_t;

    // captured loop state
    // freq and ramp carry 8 fraction bits, the default accumulator shift
    typedef struct packed {
        logic [Nerr-1:0]   phase_est;
        logic [Nerr+7:0]   freq_est;
        logic [Nerr+7:0]   ramp_est;
    } cdr_snap_t;

    typedef enum logic [1:0] {
        SNAP_SAMPLE,
        SNAP_WAIT,
        SNAP_READY
    } snap_state_t;

endpackage

//--- verilog/mm_pd.sv
`timescale 1ns/1ps
`default_nettype none

module mm_pd import cdr_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   ext_rstb,
    input  wire logic signed [Nadc-1:0] din_i [Nti],   // one interleaved word
    input  wire logic signed [Nerr-1:0] pd_offset_i,
    output logic signed [Nerr-1:0]      phase_error_o
);

    localparam int lane_bits = $clog2(Nti);
    localparam int sum_width = Nadc + 2 + lane_bits;
    localparam int err_max   = 2**(Nerr-1) - 1;
    localparam int err_min   = -(2**(Nerr-1));

    logic signed [Nadc-1:0]      last_q;        // last lane of the previous word
    logic signed [Nadc-1:0]      prev_s [Nti];  // sample before each lane
    logic signed [sum_width-1:0] pd_sum;
    logic signed [sum_width:0]   pd_diff;

    // sign of a sample, zero counts as 0
    function automatic logic signed [1:0] sgn(input logic signed [Nadc-1:0] x);
        if (x > 0) begin
            return 2'sb01;
        end else if (x < 0) begin
            return 2'sb11;
        end
        return 2'sb00;
    endfunction

    always_comb begin
        prev_s[0] = last_q;
        for (int k = 1; k < Nti; k++) begin
            prev_s[k] = din_i[k-1];
        end
    end

    // sum of x[k]*sgn(x[k-1]) - x[k-1]*sgn(x[k]) over all lanes
    always_comb begin
        logic signed [Nadc+1:0] term;
        pd_sum = '0;
        for (int k = 0; k < Nti; k++) begin
            term   = din_i[k] * sgn(prev_s[k]) - prev_s[k] * sgn(din_i[k]);
            pd_sum = pd_sum + term;
        end
    end

    always_comb begin
        pd_diff = (pd_sum >>> lane_bits) - pd_offset_i;
        if (pd_diff > err_max) begin
            phase_error_o = Nerr'(err_max);
        end else if (pd_diff < err_min) begin
            phase_error_o = Nerr'(err_min);
        end else begin
            phase_error_o = pd_diff[Nerr-1:0];
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            last_q <= '0;
        end else begin
            last_q <= din_i[Nti-1];
        end
    end

endmodule

`default_nettype wire

//--- verilog/cdr_loop_filter.sv
`timescale 1ns/1ps
`default_nettype none

module cdr_loop_filter import cdr_pkg::*; #(
    parameter int prop_width      = 3,
    parameter int intg_width      = 3,
    parameter int ramp_width      = 3,
    parameter int phase_est_shift = 8
) (
    input  wire logic                                 clk,
    input  wire logic                                 ext_rstb,
    input  wire logic signed [Nerr-1:0]               phase_error_i,
    input  wire logic                                 ramp_clock_i,
    input  wire cdr_cfg_t                             cfg_i,
    output logic [Npi-1:0]                            pi_ctl_o [Nout],
    output logic                                      freq_lvl_cross_o,
    output logic [Nerr-1:0]                           phase_est_out_o,
    output logic [Nerr+phase_est_shift-1:0]           freq_est_update_o,
    output logic [Nerr+phase_est_shift-1:0]           ramp_est_update_o
);

    localparam int acc_width = Nerr + phase_est_shift;

    logic [prop_width-1:0] kp;
    logic [intg_width-1:0] ki;
    logic [ramp_width-1:0] kr;

    logic signed [acc_width-1:0] pe_ext;
    logic signed [acc_width-1:0] ramp_step;

    logic signed [acc_width-1:0] ramp_pls_q, ramp_pls_d, ramp_pls_update;
    logic signed [acc_width-1:0] ramp_neg_q, ramp_neg_d, ramp_neg_update;
    logic signed [acc_width-1:0] freq_q, freq_d, freq_update;
    logic signed [acc_width-1:0] prev_freq_update_q;
    logic signed [acc_width-1:0] phase_q, phase_d, phase_update;

    logic [Nerr-1:0] phase_est_out;
    logic [Npi-1:0]  scaled_pi_ctl;

    assign kp = prop_width'(cfg_i.kp);
    assign ki = intg_width'(cfg_i.ki);
    assign kr = ramp_width'(cfg_i.kr);

    assign pe_ext    = acc_width'(phase_error_i);  // sign extended
    assign ramp_step = pe_ext <<< kr;

    // ramp_clock picks which half integrates this cycle
    always_comb begin
        ramp_pls_update = ramp_pls_q;
        ramp_neg_update = ramp_neg_q;
        if (ramp_clock_i) begin
            ramp_pls_update = ramp_pls_q + ramp_step;
        end else begin
            ramp_neg_update = ramp_neg_q + ramp_step;
        end
        ramp_pls_d = cfg_i.en_ramp_est ? ramp_pls_update : '0;
        ramp_neg_d = cfg_i.en_ramp_est ? ramp_neg_update : '0;
    end

    always_comb begin
        freq_update = freq_q + (pe_ext <<< ki)
                    + (ramp_clock_i ? ramp_pls_q : ramp_neg_q);
        freq_d      = cfg_i.en_freq_est ? freq_update : '0;

        phase_update = (pe_ext <<< kp) + freq_q;
        phase_d      = phase_q + phase_update;
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ramp_pls_q         <= '0;
            ramp_neg_q         <= '0;
            freq_q             <= '0;
            prev_freq_update_q <= '0;
            phase_q            <= '0;
        end else begin
            ramp_pls_q         <= ramp_pls_d;
            ramp_neg_q         <= ramp_neg_d;
            freq_q             <= freq_d;
            prev_freq_update_q <= freq_update;
            phase_q            <= phase_d;
        end
    end

    // flag a rising frequency update
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            freq_lvl_cross_o <= 1'b0;
        end else begin
            freq_lvl_cross_o <= (freq_update > prev_freq_update_q);
        end
    end

    assign phase_est_out = phase_q[acc_width-1:phase_est_shift];  // drop fraction bits
    assign scaled_pi_ctl = phase_est_out[Nerr-1:Nerr-Npi];

    for (genvar k = 0; k < Nout; k++) begin : g_pi_ctl
        assign pi_ctl_o[k] = cfg_i.en_ext_pi_ctl ? cfg_i.ext_pi_ctl : scaled_pi_ctl;
    end

    assign phase_est_out_o   = phase_est_out;
    assign freq_est_update_o = freq_update;
    assign ramp_est_update_o = ramp_clock_i ? ramp_pls_update : ramp_neg_update;

endmodule

`default_nettype wire

//--- verilog/cdr_snapshot.sv
`timescale 1ns/1ps
`default_nettype none

module cdr_snapshot import cdr_pkg::*; #(
    parameter int phase_est_shift = 8
) (
    input  wire logic                              clk,
    input  wire logic                              ext_rstb,
    input  wire logic                              sample_req_i,  // level request
    input  wire logic [Nerr-1:0]                   phase_est_i,
    input  wire logic [Nerr+phase_est_shift-1:0]   freq_est_i,
    input  wire logic [Nerr+phase_est_shift-1:0]   ramp_est_i,
    output cdr_snap_t                              snap_o
);

    snap_state_t state;

    // request must drop before the next capture is armed
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state  <= SNAP_WAIT;
            snap_o <= '0;
        end else begin
            case (state)
                SNAP_SAMPLE: begin
                    snap_o.phase_est <= phase_est_i;
                    snap_o.freq_est  <= freq_est_i;
                    snap_o.ramp_est  <= ramp_est_i;
                    state            <= SNAP_WAIT;
                end
                SNAP_WAIT: begin
                    if (!sample_req_i) begin
                        state <= SNAP_READY;
                    end
                end
                SNAP_READY: begin
                    if (sample_req_i) begin
                        state <= SNAP_SAMPLE;
                    end
                end
                default: begin
                    state <= SNAP_WAIT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/cdr_top.sv
`timescale 1ns/1ps
`default_nettype none

module cdr_top import cdr_pkg::*; #(
    parameter int prop_width      = 3,
    parameter int intg_width      = 3,
    parameter int ramp_width      = 3,
    parameter int phase_est_shift = 8
) (
    input  wire logic                   clk,
    input  wire logic                   ext_rstb,
    input  wire logic signed [Nadc-1:0] din_i [Nti],
    input  wire logic                   ramp_clock_i,  // treated as synchronous to clk
    input  wire cdr_cfg_t               cfg_i,
    input  wire logic                   sample_req_i,
    output logic [Npi-1:0]              pi_ctl_o [Nout],
    output logic                        freq_lvl_cross_o,
    output cdr_snap_t                   snap_o
);

    logic signed [Nerr-1:0]               phase_error;
    logic [Nerr-1:0]                      phase_est_out;
    logic [Nerr+phase_est_shift-1:0]      freq_est_update;
    logic [Nerr+phase_est_shift-1:0]      ramp_est_update;

    // snapshot fields are sized for 8 fraction bits
    if (phase_est_shift != 8) begin : g_shift_check
        $error("cdr_top: phase_est_shift must be 8 to fit cdr_snap_t");
    end

    mm_pd mm_pd_inst (
        .clk           (clk),
        .ext_rstb      (ext_rstb),
        .din_i         (din_i),
        .pd_offset_i   (cfg_i.pd_offset),
        .phase_error_o (phase_error)
    );

    cdr_loop_filter #(
        .prop_width      (prop_width),
        .intg_width      (intg_width),
        .ramp_width      (ramp_width),
        .phase_est_shift (phase_est_shift)
    ) cdr_loop_filter_inst (
        .clk               (clk),
        .ext_rstb          (ext_rstb),
        .phase_error_i     (phase_error),
        .ramp_clock_i      (ramp_clock_i),
        .cfg_i             (cfg_i),
        .pi_ctl_o          (pi_ctl_o),
        .freq_lvl_cross_o  (freq_lvl_cross_o),
        .phase_est_out_o   (phase_est_out),
        .freq_est_update_o (freq_est_update),
        .ramp_est_update_o (ramp_est_update)
    );

    cdr_snapshot #(
        .phase_est_shift (phase_est_shift)
    ) cdr_snapshot_inst (
        .clk          (clk),
        .ext_rstb     (ext_rstb),
        .sample_req_i (sample_req_i),
        .phase_est_i  (phase_est_out),
        .freq_est_i   (freq_est_update),
        .ramp_est_i   (ramp_est_update),
        .snap_o       (snap_o)
    );

endmodule

`default_nettype wire

//--- test/cdr_asserts.sv
`timescale 1ns/1ps

module cdr_asserts import cdr_pkg::*; (
    input logic                   clk,
    input logic                   ext_rstb,
    input cdr_cfg_t               cfg_i,
    input logic                   sample_req_i,
    input logic signed [Nerr-1:0] phase_error_i,
    input logic [Npi-1:0]         pi_ctl_i [Nout],
    input logic                   freq_lvl_cross_i,
    input cdr_snap_t              snap_i
);

    int fail_count = 0;

    for (genvar k = 0; k < Nout; k++) begin : g_lane
        // lanes read zero in reset and on the first edge out of it
        a_lane_reset: assert property (@(posedge clk)
            (!ext_rstb || $rose(ext_rstb)) |-> pi_ctl_i[k] == '0)
        else begin
            fail_count++;
            $error("pi_ctl lane %0d is not zero around reset", k);
        end

        a_lane_override: assert property (@(posedge clk) disable iff (!ext_rstb)
            cfg_i.en_ext_pi_ctl |-> pi_ctl_i[k] == cfg_i.ext_pi_ctl)
        else begin
            fail_count++;
            $error("pi_ctl lane %0d does not follow ext_pi_ctl", k);
        end
    end

    a_reset_state: assert property (@(posedge clk)
        (!ext_rstb || $rose(ext_rstb)) |-> (!freq_lvl_cross_i && snap_i == '0))
    else begin
        fail_count++;
        $error("freq_lvl_cross_o or snap_o not zero around reset");
    end

    // zero error on a settled integrator leaves the freq update flat
    a_freq_flag_falls: assert property (@(posedge clk) disable iff (!ext_rstb)
        ($past(cfg_i.en_freq_est && !cfg_i.en_ramp_est) && phase_error_i == '0)
        |=> !freq_lvl_cross_i)
    else begin
        fail_count++;
        $error("freq_lvl_cross_o stayed high with zero phase error");
    end

    a_one_capture: assert property (@(posedge clk) disable iff (!ext_rstb)
        (sample_req_i && $past(sample_req_i, 1) && $past(sample_req_i, 2)
            && $past(sample_req_i, 3)) |-> $stable(snap_i))
    else begin
        fail_count++;
        $error("snap_o changed again while sample_req_i stayed high");
    end

endmodule

bind cdr_top cdr_asserts cdr_asserts_inst (
    .clk              (clk),
    .ext_rstb         (ext_rstb),
    .cfg_i            (cfg_i),
    .sample_req_i     (sample_req_i),
    .phase_error_i    (phase_error),
    .pi_ctl_i         (pi_ctl_o),
    .freq_lvl_cross_i (freq_lvl_cross_o),
    .snap_i           (snap_o)
);

//--- test/tb_cdr.sv
`timescale 1ns/1ps

module tb_cdr import cdr_pkg::*; ();

    localparam int phase_est_shift = 8;
    localparam int snap_timeout    = 20;  // cycles per wait
    localparam int hold_cycles     = 5;

    logic                   clk;
    logic                   ext_rstb;
    logic signed [Nadc-1:0] din [Nti];
    logic                   ramp_clock;
    cdr_cfg_t               cfg;
    logic                   sample_req;
    logic [Npi-1:0]         pi_ctl [Nout];
    logic                   freq_lvl_cross;
    cdr_snap_t              snap;

    int seed;
    int cycle;
    int error_count;
    bit timed_out;

    cdr_top #(
        .prop_width      (3),
        .intg_width      (3),
        .ramp_width      (3),
        .phase_est_shift (phase_est_shift)
    ) cdr_top_inst (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .din_i            (din),
        .ramp_clock_i     (ramp_clock),
        .cfg_i            (cfg),
        .sample_req_i     (sample_req),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (freq_lvl_cross),
        .snap_o           (snap)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;  // edge index
    end

    function automatic int random_gap();
        return 2 + ($random(seed) & 7);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic compare_value(input string name, input logic [Nerr+7:0] got,
                                 input logic [Nerr+7:0] expected);
        if (timed_out) begin
            return;
        end
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, got);
        end
    endtask

    // raise the request from READY, return the edge it was raised on
    task automatic take_snapshot(output int req_cycle, output cdr_snap_t captured);
        int waited;
        bit seen_sample;
        req_cycle = 0;
        captured  = '0;
        if (timed_out) begin
            return;
        end
        waited = 0;
        @(negedge clk);
        while (cdr_top_inst.cdr_snapshot_inst.state != SNAP_READY) begin
            if (waited >= snap_timeout) begin
                timed_out = 1'b1;
                $display("timeout: snapshot sampler did not arm within %0d cycles", waited);
                return;
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        sample_req <= 1'b1;
        req_cycle   = cycle;
        waited      = 0;
        seen_sample = 1'b0;
        while (!seen_sample || cdr_top_inst.cdr_snapshot_inst.state == SNAP_SAMPLE) begin
            if (waited >= snap_timeout) begin
                timed_out = 1'b1;
                $display("timeout: snapshot was not captured within %0d cycles", waited);
                return;
            end
            waited++;
            @(negedge clk);
            if (cdr_top_inst.cdr_snapshot_inst.state == SNAP_SAMPLE) begin
                seen_sample = 1'b1;
            end
        end
        captured = snap;
        idle_cycles(hold_cycles);  // request stays high, no second capture
        sample_req <= 1'b0;
    endtask

    task automatic zero_word();
        for (int k = 0; k < Nti; k++) begin
            din[k] <= '0;
        end
    endtask

    initial begin
        int              ra;
        int              rb;
        int              en_cycle;
        int              assert_fails;
        cdr_snap_t       sa;
        cdr_snap_t       sb;
        logic [Nerr-1:0] delta;
        seed        = 8;
        cycle       = 0;
        error_count = 0;
        timed_out   = 1'b0;
        ext_rstb    = 1'b0;
        ramp_clock  = 1'b0;
        cfg         = '0;
        sample_req  = 1'b0;
        for (int k = 0; k < Nti; k++) begin
            din[k] = '0;
        end

        idle_cycles(8);
        ext_rstb <= 1'b1;
        idle_cycles(4);

        // override with random codes over random samples
        for (int n = 0; n < 24; n++) begin
            @(posedge clk);
            cfg.en_ext_pi_ctl <= 1'b1;
            cfg.ext_pi_ctl    <= Npi'($random(seed));
            for (int k = 0; k < Nti; k++) begin
                din[k] <= Nadc'($random(seed));
            end
        end
        @(posedge clk);
        cfg.en_ext_pi_ctl <= 1'b0;
        zero_word();

        // error +2 with kp 7 steps phase by 2**8, one phase_est count per cycle
        @(posedge clk);
        cfg.kp        <= 3'd7;
        cfg.pd_offset <= Nerr'(-2);
        idle_cycles(4);
        take_snapshot(ra, sa);
        idle_cycles(random_gap());
        take_snapshot(rb, sb);
        delta = sb.phase_est - sa.phase_est;
        compare_value("snap_o.phase_est delta", delta, (Nerr+8)'(Nerr'(rb - ra)));

        // integral path, error +1 and ki 2
        @(posedge clk);
        cfg.pd_offset <= Nerr'(-1);
        cfg.ki        <= 3'd2;
        idle_cycles(3);
        @(posedge clk);
        cfg.en_freq_est <= 1'b1;
        en_cycle = cycle;
        idle_cycles(random_gap());
        take_snapshot(ra, sa);
        compare_value("snap_o.freq_est", sa.freq_est, (Nerr+8)'(4 * (ra + 2 - en_cycle)));
        @(negedge clk);
        compare_value("freq_lvl_cross_o", freq_lvl_cross, (Nerr+8)'(1));
        idle_cycles(random_gap());
        take_snapshot(rb, sb);
        compare_value("snap_o.freq_est", sb.freq_est, (Nerr+8)'(4 * (rb + 2 - en_cycle)));
        @(posedge clk);
        cfg.pd_offset <= '0;  // flag must fall
        idle_cycles(6);
        @(posedge clk);
        cfg.en_freq_est <= 1'b0;

        // ramp path, high half first
        @(posedge clk);
        cfg.pd_offset <= Nerr'(-1);
        cfg.kr        <= 3'd1;
        ramp_clock    <= 1'b1;
        idle_cycles(2);
        @(posedge clk);
        cfg.en_ramp_est <= 1'b1;
        en_cycle = cycle;
        idle_cycles(random_gap());
        take_snapshot(ra, sa);
        compare_value("snap_o.ramp_est", sa.ramp_est, (Nerr+8)'(2 * (ra + 2 - en_cycle)));
        idle_cycles(random_gap());
        take_snapshot(rb, sb);
        compare_value("snap_o.ramp_est", sb.ramp_est, (Nerr+8)'(2 * (rb + 2 - en_cycle)));
        @(posedge clk);
        ramp_clock <= 1'b0;  // negative half was held at zero
        en_cycle = cycle;
        idle_cycles(random_gap());
        take_snapshot(ra, sa);
        compare_value("snap_o.ramp_est", sa.ramp_est, (Nerr+8)'(2 * (ra + 2 - en_cycle)));
        @(posedge clk);
        cfg.en_ramp_est <= 1'b0;
        idle_cycles(4);

        assert_fails = cdr_top_inst.cdr_asserts_inst.fail_count;
        $display("tb check errors: %0d, assertion failures: %0d, timeouts: %0d",
                 error_count, assert_fails, timed_out);
        if (error_count == 0 && assert_fails == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
verilog/cdr_pkg.sv
verilog/mm_pd.sv
verilog/cdr_loop_filter.sv
verilog/cdr_snapshot.sv
verilog/cdr_top.sv
test/cdr_asserts.sv
test/tb_cdr.sv

//--- run.sh
#!/bin/sh
# build and run the cdr testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_cdr -f list.f -o sim_tb_cdr

# let assertion errors be counted instead of stopping at the first one
./obj_dir/sim_tb_cdr +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -qx '>>> PASS' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
